// ==== bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// entries per credit FIFO, which is also the credit count a sender starts with
`define BRIDGE_FIFO_DEPTH 4

// core I/O writes below this address land in the host mailbox
`define BRIDGE_SPLIT_ADDR 32'h0020_0000

// core DRAM starts here, so the remap XORs it away before adding the host base
`define BRIDGE_DRAM_XOR 32'h8000_0000

// host register map, word indices
`define BRIDGE_CSR_CTRL       0
`define BRIDGE_CSR_DRAM_OK    1
`define BRIDGE_CSR_DRAM_BASE  2
`define BRIDGE_CSR_MBOX_COUNT 3
`define BRIDGE_CSR_MBOX_DATA  4
// profiler words sit at PROF0 through PROF0+3
`define BRIDGE_CSR_PROF0      5

// core address bits that pick one of the 128 profiler bits
`define BRIDGE_PROF_MSB 29
`define BRIDGE_PROF_LSB 23

`endif

// ==== bridge_pkg.sv ====
package bridge_pkg;

   // core side or host DRAM side address
   typedef logic [31:0] addr_t;

   // the host window only sees 30 address bits
   typedef logic [29:0] host_addr_t;

   typedef logic [31:0]  data_t;
   typedef logic [7:0]   mbox_byte_t;
   typedef logic [3:0]   csr_idx_t;

   // holds 0 up to the FIFO depth of 4
   typedef logic [2:0]   credit_t;

   // one bit per DRAM region touched by the core
   typedef logic [127:0] profile_t;

   // request from the host into the core address window
   typedef struct packed {
      logic       we;
      host_addr_t addr;
      data_t      data;
   } host_req_t;

   // request on the core side, used for host forwarding and for DRAM
   typedef struct packed {
      logic  we;
      addr_t addr;
      data_t data;
   } core_req_t;

   // posted I/O write from the core
   typedef struct packed {
      addr_t addr;
      data_t data;
   } io_wr_t;

   // host register access
   typedef struct packed {
      logic     we;
      csr_idx_t idx;
      data_t    data;
   } csr_req_t;

endpackage

// ==== credit_fifo.sv ====
`timescale 1ns/100ps

module credit_fifo
  #(parameter int data_width_p = 32
    , parameter int depth_p    = 4
    )
   (input  logic                    clk_i
    , input  logic                    reset_i
    , input  logic                    push_v_i
    , input  logic [data_width_p-1:0] push_data_i
    , input  logic                    pop_i
    , output logic                    head_v_o
    , output logic [data_width_p-1:0] head_data_o
    , output bridge_pkg::credit_t     count_o
    , output logic                    credit_o
    );

   localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;

   logic [data_width_p-1:0] mem_r [depth_p];
   logic [ptr_width_lp-1:0] wptr_r;
   logic [ptr_width_lp-1:0] rptr_r;
   bridge_pkg::credit_t     count_r;
   logic                    credit_r;
   logic                    push_li;
   logic                    pop_li;

   // pointers wrap at the depth, which need not be a power of two
   function automatic logic [ptr_width_lp-1:0] ptr_inc(input logic [ptr_width_lp-1:0] ptr);
      if (ptr == ptr_width_lp'(depth_p - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   // the sender never overruns while it honours its credits
   assign push_li = push_v_i && (count_r != bridge_pkg::credit_t'(depth_p));
   assign pop_li  = pop_i && (count_r != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_r   <= '0;
         rptr_r   <= '0;
         count_r  <= '0;
         credit_r <= 1'b0;
      end else begin
         if (push_li)
            wptr_r <= ptr_inc(wptr_r);
         if (pop_li)
            rptr_r <= ptr_inc(rptr_r);
         case ({push_li, pop_li})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
         // every freed entry goes back to the sender one cycle later
         credit_r <= pop_li;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_li)
         mem_r[wptr_r] <= push_data_i;
   end

   assign head_v_o    = (count_r != '0);
   assign head_data_o = mem_r[rptr_r];
   assign count_o     = count_r;
   assign credit_o    = credit_r;

endmodule

// ==== csr_regfile.sv ====
`timescale 1ns/100ps

`include "bridge_settings.svh"

module csr_regfile
   (input  logic                   clk_i
    , input  logic                   reset_i
    , input  logic                   csr_req_v_i
    , input  bridge_pkg::csr_req_t   csr_req_i
    , output logic                   csr_rdata_v_o
    , output bridge_pkg::data_t      csr_rdata_o
    , input  logic                   mbox_v_i
    , input  bridge_pkg::mbox_byte_t mbox_byte_i
    , output logic                   mbox_credit_o
    , input  bridge_pkg::profile_t   profile_i
    , output bridge_pkg::addr_t      dram_base_o
    , output logic                   core_reset_o
    );

   bridge_pkg::data_t      ctrl_r;
   logic                   dram_ok_r;
   bridge_pkg::addr_t      dram_base_r;
   logic                   rdata_v_r;
   bridge_pkg::data_t      rdata_r;
   bridge_pkg::data_t      rdata_n;
   logic                   mbox_head_v_lo;
   bridge_pkg::mbox_byte_t mbox_head_lo;
   bridge_pkg::credit_t    mbox_count_lo;
   logic                   mbox_pop_li;
   logic                   csr_rd_li;
   logic                   csr_wr_li;

   assign csr_rd_li = csr_req_v_i && !csr_req_i.we;
   assign csr_wr_li = csr_req_v_i && csr_req_i.we;

   // reading the data word consumes one byte, an empty mailbox stays as it is
   assign mbox_pop_li = csr_rd_li && (csr_req_i.idx == `BRIDGE_CSR_MBOX_DATA) && mbox_head_v_lo;

   credit_fifo
     #(.data_width_p($bits(bridge_pkg::mbox_byte_t))
       ,.depth_p(`BRIDGE_FIFO_DEPTH)
       )
   mbox
     (.clk_i       (clk_i)
      ,.reset_i    (reset_i)
      ,.push_v_i   (mbox_v_i)
      ,.push_data_i(mbox_byte_i)
      ,.pop_i      (mbox_pop_li)
      ,.head_v_o   (mbox_head_v_lo)
      ,.head_data_o(mbox_head_lo)
      ,.count_o    (mbox_count_lo)
      ,.credit_o   (mbox_credit_o)
      );

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_r      <= '0;
         dram_ok_r   <= 1'b0;
         dram_base_r <= '0;
      end else if (csr_wr_li) begin
         case (csr_req_i.idx)
            `BRIDGE_CSR_CTRL:      ctrl_r      <= csr_req_i.data;
            `BRIDGE_CSR_DRAM_OK:   dram_ok_r   <= csr_req_i.data[0];
            `BRIDGE_CSR_DRAM_BASE: dram_base_r <= csr_req_i.data;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (csr_req_i.idx)
         `BRIDGE_CSR_CTRL:       rdata_n = ctrl_r;
         `BRIDGE_CSR_DRAM_OK:    rdata_n = bridge_pkg::data_t'(dram_ok_r);
         `BRIDGE_CSR_DRAM_BASE:  rdata_n = dram_base_r;
         `BRIDGE_CSR_MBOX_COUNT: rdata_n = bridge_pkg::data_t'(mbox_count_lo);
         `BRIDGE_CSR_MBOX_DATA:
            rdata_n = mbox_head_v_lo ? bridge_pkg::data_t'(mbox_head_lo) : '0;
         `BRIDGE_CSR_PROF0:      rdata_n = profile_i[31:0];
         `BRIDGE_CSR_PROF0 + 1:  rdata_n = profile_i[63:32];
         `BRIDGE_CSR_PROF0 + 2:  rdata_n = profile_i[95:64];
         `BRIDGE_CSR_PROF0 + 3:  rdata_n = profile_i[127:96];
         default:                rdata_n = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i)
         rdata_v_r <= 1'b0;
      else
         rdata_v_r <= csr_rd_li;
   end

   always_ff @(posedge clk_i) begin
      if (csr_rd_li)
         rdata_r <= rdata_n;
   end

   assign csr_rdata_v_o = rdata_v_r;
   assign csr_rdata_o   = rdata_r;
   assign dram_base_o   = dram_base_r;

   // the core only runs once the host sets the run bit
   assign core_reset_o = reset_i || !ctrl_r[0];

endmodule

// ==== host_window.sv ====
`timescale 1ns/100ps

`include "bridge_settings.svh"

module host_window
   (input  logic                  clk_i
    , input  logic                  reset_i
    , input  logic                  host_req_v_i
    , input  bridge_pkg::host_req_t host_req_i
    , output logic                  host_credit_o
    , output logic                  core_host_req_v_o
    , output bridge_pkg::core_req_t core_host_req_o
    , input  logic                  core_host_credit_i
    );

   bridge_pkg::host_req_t head_lo;
   logic                  head_v_lo;
   logic                  send_lo;
   bridge_pkg::credit_t   credits_r;

   credit_fifo
     #(.data_width_p($bits(bridge_pkg::host_req_t))
       ,.depth_p(`BRIDGE_FIFO_DEPTH)
       )
   fifo
     (.clk_i       (clk_i)
      ,.reset_i    (reset_i)
      ,.push_v_i   (host_req_v_i)
      ,.push_data_i(host_req_i)
      ,.pop_i      (send_lo)
      ,.head_v_o   (head_v_lo)
      ,.head_data_o(head_lo)
      ,.count_o    ()
      ,.credit_o   (host_credit_o)
      );

   assign send_lo = head_v_lo && (credits_r != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i)
         credits_r <= bridge_pkg::credit_t'(`BRIDGE_FIFO_DEPTH);
      else if (send_lo && !core_host_credit_i)
         credits_r <= credits_r - 1'b1;
      else if (!send_lo && core_host_credit_i)
         credits_r <= credits_r + 1'b1;
   end

   // host 0x0xxx_xxxx maps to core DRAM at 0x8xxx_xxxx and host 0x2xxx_xxxx to core 0x0xxx_xxxx
   always_comb begin
      core_host_req_o.we   = head_lo.we;
      core_host_req_o.addr = {~head_lo.addr[29], 3'b000, head_lo.addr[27:0]};
      core_host_req_o.data = head_lo.data;
   end

   assign core_host_req_v_o = send_lo;

endmodule

// ==== io_router.sv ====
`timescale 1ns/100ps

`include "bridge_settings.svh"

module io_router
   (input  logic                   clk_i
    , input  logic                   reset_i
    , input  logic                   core_io_req_v_i
    , input  bridge_pkg::io_wr_t     core_io_req_i
    , output logic                   core_io_credit_o
    , output logic                   mbox_v_o
    , output bridge_pkg::mbox_byte_t mbox_byte_o
    , input  logic                   mbox_credit_i
    , output logic                   periph_wr_v_o
    , output bridge_pkg::io_wr_t     periph_wr_o
    , input  logic                   periph_credit_i
    );

   bridge_pkg::io_wr_t  head_lo;
   logic                head_v_lo;
   logic                to_mbox_lo;
   logic                mbox_send_lo;
   logic                periph_send_lo;
   bridge_pkg::credit_t mbox_credits_r;
   bridge_pkg::credit_t periph_credits_r;

   credit_fifo
     #(.data_width_p($bits(bridge_pkg::io_wr_t))
       ,.depth_p(`BRIDGE_FIFO_DEPTH)
       )
   fifo
     (.clk_i       (clk_i)
      ,.reset_i    (reset_i)
      ,.push_v_i   (core_io_req_v_i)
      ,.push_data_i(core_io_req_i)
      ,.pop_i      (mbox_send_lo || periph_send_lo)
      ,.head_v_o   (head_v_lo)
      ,.head_data_o(head_lo)
      ,.count_o    ()
      ,.credit_o   (core_io_credit_o)
      );

   // only the head destination is checked, so a stalled head holds up the queue
   assign to_mbox_lo     = (head_lo.addr < bridge_pkg::addr_t'(`BRIDGE_SPLIT_ADDR));
   assign mbox_send_lo   = head_v_lo && to_mbox_lo && (mbox_credits_r != '0);
   assign periph_send_lo = head_v_lo && !to_mbox_lo && (periph_credits_r != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i)
         mbox_credits_r <= bridge_pkg::credit_t'(`BRIDGE_FIFO_DEPTH);
      else if (mbox_send_lo && !mbox_credit_i)
         mbox_credits_r <= mbox_credits_r - 1'b1;
      else if (!mbox_send_lo && mbox_credit_i)
         mbox_credits_r <= mbox_credits_r + 1'b1;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i)
         periph_credits_r <= bridge_pkg::credit_t'(`BRIDGE_FIFO_DEPTH);
      else if (periph_send_lo && !periph_credit_i)
         periph_credits_r <= periph_credits_r - 1'b1;
      else if (!periph_send_lo && periph_credit_i)
         periph_credits_r <= periph_credits_r + 1'b1;
   end

   // the mailbox carries a byte stream, so only the low byte is kept
   assign mbox_v_o      = mbox_send_lo;
   assign mbox_byte_o   = head_lo.data[7:0];
   assign periph_wr_v_o = periph_send_lo;
   assign periph_wr_o   = head_lo;

endmodule

// ==== dram_window.sv ====
`timescale 1ns/100ps

`include "bridge_settings.svh"

module dram_window
   (input  logic                  clk_i
    , input  logic                  reset_i
    , input  logic                  core_reset_i
    , input  logic                  core_dram_req_v_i
    , input  bridge_pkg::core_req_t core_dram_req_i
    , output logic                  core_dram_credit_o
    , input  bridge_pkg::addr_t     dram_base_i
    , output logic                  dram_req_v_o
    , output bridge_pkg::core_req_t dram_req_o
    , input  logic                  dram_credit_i
    , output bridge_pkg::profile_t  profile_o
    );

   bridge_pkg::core_req_t                       head_lo;
   logic                                        head_v_lo;
   logic                                        send_lo;
   bridge_pkg::credit_t                         credits_r;
   bridge_pkg::profile_t                        profile_r;
   logic [`BRIDGE_PROF_MSB-`BRIDGE_PROF_LSB:0]  prof_idx_li;

   credit_fifo
     #(.data_width_p($bits(bridge_pkg::core_req_t))
       ,.depth_p(`BRIDGE_FIFO_DEPTH)
       )
   fifo
     (.clk_i       (clk_i)
      ,.reset_i    (reset_i)
      ,.push_v_i   (core_dram_req_v_i)
      ,.push_data_i(core_dram_req_i)
      ,.pop_i      (send_lo)
      ,.head_v_o   (head_v_lo)
      ,.head_data_o(head_lo)
      ,.count_o    ()
      ,.credit_o   (core_dram_credit_o)
      );

   assign send_lo = head_v_lo && (credits_r != '0);

   always_ff @(posedge clk_i) begin
      if (reset_i)
         credits_r <= bridge_pkg::credit_t'(`BRIDGE_FIFO_DEPTH);
      else if (send_lo && !dram_credit_i)
         credits_r <= credits_r - 1'b1;
      else if (!send_lo && dram_credit_i)
         credits_r <= credits_r + 1'b1;
   end

   // strip the core DRAM base, then place the request in the host allocated region
   always_comb begin
      dram_req_o.we   = head_lo.we;
      dram_req_o.addr = (head_lo.addr ^ bridge_pkg::addr_t'(`BRIDGE_DRAM_XOR)) + dram_base_i;
      dram_req_o.data = head_lo.data;
   end

   assign dram_req_v_o = send_lo;

   // each bit covers an 8 MB region of core address space
   assign prof_idx_li = core_dram_req_i.addr[`BRIDGE_PROF_MSB:`BRIDGE_PROF_LSB];

   always_ff @(posedge clk_i) begin
      if (reset_i || core_reset_i)
         profile_r <= '0;
      else if (core_dram_req_v_i)
         profile_r <= profile_r | (bridge_pkg::profile_t'(1) << prof_idx_li);
   end

   assign profile_o = profile_r;

endmodule

// ==== zynq_bridge_top.sv ====
`timescale 1ns/100ps

module zynq_bridge_top
   (input  logic                  clk_i
    , input  logic                  reset_i

    // host register port
    , input  logic                  csr_req_v_i
    , input  bridge_pkg::csr_req_t  csr_req_i
    , output logic                  csr_rdata_v_o
    , output bridge_pkg::data_t     csr_rdata_o
    , output logic                  core_reset_o

    // host window into the core
    , input  logic                  host_req_v_i
    , input  bridge_pkg::host_req_t host_req_i
    , output logic                  host_credit_o
    , output logic                  core_host_req_v_o
    , output bridge_pkg::core_req_t core_host_req_o
    , input  logic                  core_host_credit_i

    // core I/O writes
    , input  logic                  core_io_req_v_i
    , input  bridge_pkg::io_wr_t    core_io_req_i
    , output logic                  core_io_credit_o
    , output logic                  periph_wr_v_o
    , output bridge_pkg::io_wr_t    periph_wr_o
    , input  logic                  periph_credit_i

    // core DRAM requests
    , input  logic                  core_dram_req_v_i
    , input  bridge_pkg::core_req_t core_dram_req_i
    , output logic                  core_dram_credit_o
    , output logic                  dram_req_v_o
    , output bridge_pkg::core_req_t dram_req_o
    , input  logic                  dram_credit_i
    );

   logic                   mbox_v_lo;
   bridge_pkg::mbox_byte_t mbox_byte_lo;
   logic                   mbox_credit_lo;
   bridge_pkg::profile_t   profile_lo;
   bridge_pkg::addr_t      dram_base_lo;

   csr_regfile csr
     (.clk_i(clk_i), .reset_i(reset_i)
      ,.csr_req_v_i(csr_req_v_i), .csr_req_i(csr_req_i)
      ,.csr_rdata_v_o(csr_rdata_v_o), .csr_rdata_o(csr_rdata_o)
      ,.mbox_v_i(mbox_v_lo), .mbox_byte_i(mbox_byte_lo), .mbox_credit_o(mbox_credit_lo)
      ,.profile_i(profile_lo), .dram_base_o(dram_base_lo), .core_reset_o(core_reset_o)
      );

   host_window host
     (.clk_i(clk_i), .reset_i(reset_i)
      ,.host_req_v_i(host_req_v_i), .host_req_i(host_req_i), .host_credit_o(host_credit_o)
      ,.core_host_req_v_o(core_host_req_v_o), .core_host_req_o(core_host_req_o)
      ,.core_host_credit_i(core_host_credit_i)
      );

   io_router io
     (.clk_i(clk_i), .reset_i(reset_i)
      ,.core_io_req_v_i(core_io_req_v_i), .core_io_req_i(core_io_req_i)
      ,.core_io_credit_o(core_io_credit_o)
      ,.mbox_v_o(mbox_v_lo), .mbox_byte_o(mbox_byte_lo), .mbox_credit_i(mbox_credit_lo)
      ,.periph_wr_v_o(periph_wr_v_o), .periph_wr_o(periph_wr_o)
      ,.periph_credit_i(periph_credit_i)
      );

   dram_window dram
     (.clk_i(clk_i), .reset_i(reset_i), .core_reset_i(core_reset_o)
      ,.core_dram_req_v_i(core_dram_req_v_i), .core_dram_req_i(core_dram_req_i)
      ,.core_dram_credit_o(core_dram_credit_o), .dram_base_i(dram_base_lo)
      ,.dram_req_v_o(dram_req_v_o), .dram_req_o(dram_req_o), .dram_credit_i(dram_credit_i)
      ,.profile_o(profile_lo)
      );

endmodule

// ==== tb_zynq_bridge.sv ====
`timescale 1ns/100ps

`include "bridge_settings.svh"

module tb_zynq_bridge;

   localparam int depth_lp      = `BRIDGE_FIFO_DEPTH;
   localparam int wait_limit_lp = 50;

   // what a table row does
   localparam logic [2:0] op_level = 3'd0;
   localparam logic [2:0] op_write = 3'd1;
   localparam logic [2:0] op_read  = 3'd2;
   localparam logic [2:0] op_send  = 3'd3;
   localparam logic [2:0] op_burst = 3'd4;

   // which port a row works on
   localparam logic [2:0] ch_top    = 3'd0;
   localparam logic [2:0] ch_csr    = 3'd1;
   localparam logic [2:0] ch_host   = 3'd2;
   localparam logic [2:0] ch_dram   = 3'd3;
   localparam logic [2:0] ch_mbox   = 3'd4;
   localparam logic [2:0] ch_periph = 3'd5;

   typedef struct packed {
      logic [2:0]  op;
      logic [2:0]  ch;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp;
   } row_t;

   logic                  clk_i;
   logic                  reset_i;
   logic                  csr_req_v_i;
   bridge_pkg::csr_req_t  csr_req_i;
   logic                  csr_rdata_v_o;
   bridge_pkg::data_t     csr_rdata_o;
   logic                  core_reset_o;
   logic                  host_req_v_i;
   bridge_pkg::host_req_t host_req_i;
   logic                  host_credit_o;
   logic                  core_host_req_v_o;
   bridge_pkg::core_req_t core_host_req_o;
   logic                  core_host_credit_i;
   logic                  core_io_req_v_i;
   bridge_pkg::io_wr_t    core_io_req_i;
   logic                  core_io_credit_o;
   logic                  periph_wr_v_o;
   bridge_pkg::io_wr_t    periph_wr_o;
   logic                  periph_credit_i;
   logic                  core_dram_req_v_i;
   bridge_pkg::core_req_t core_dram_req_i;
   logic                  core_dram_credit_o;
   logic                  dram_req_v_o;
   bridge_pkg::core_req_t dram_req_o;
   logic                  dram_credit_i;

   row_t                  rows [$];
   bridge_pkg::core_req_t host_out_q [$];
   bridge_pkg::core_req_t dram_out_q [$];
   bridge_pkg::io_wr_t    periph_out_q [$];
   int                    host_seen;
   int                    io_seen;
   int                    dram_seen;
   int                    host_sent;
   int                    io_sent;
   int                    dram_sent;
   int                    errors;
   int                    checks;
   logic [31:0]           lfsr_r;

   zynq_bridge_top dut
     (.clk_i(clk_i), .reset_i(reset_i)
      ,.csr_req_v_i(csr_req_v_i), .csr_req_i(csr_req_i)
      ,.csr_rdata_v_o(csr_rdata_v_o), .csr_rdata_o(csr_rdata_o)
      ,.core_reset_o(core_reset_o)
      ,.host_req_v_i(host_req_v_i), .host_req_i(host_req_i), .host_credit_o(host_credit_o)
      ,.core_host_req_v_o(core_host_req_v_o), .core_host_req_o(core_host_req_o)
      ,.core_host_credit_i(core_host_credit_i)
      ,.core_io_req_v_i(core_io_req_v_i), .core_io_req_i(core_io_req_i)
      ,.core_io_credit_o(core_io_credit_o)
      ,.periph_wr_v_o(periph_wr_v_o), .periph_wr_o(periph_wr_o)
      ,.periph_credit_i(periph_credit_i)
      ,.core_dram_req_v_i(core_dram_req_v_i), .core_dram_req_i(core_dram_req_i)
      ,.core_dram_credit_o(core_dram_credit_o)
      ,.dram_req_v_o(dram_req_v_o), .dram_req_o(dram_req_o), .dram_credit_i(dram_credit_i)
      );

   always #20 clk_i = ~clk_i;

   // outputs are collected on the rising edge, the driver looks at them on the falling one
   always @(posedge clk_i) begin
      if (!reset_i) begin
         if (core_host_req_v_o)
            host_out_q.push_back(core_host_req_o);
         if (dram_req_v_o)
            dram_out_q.push_back(dram_req_o);
         if (periph_wr_v_o)
            periph_out_q.push_back(periph_wr_o);
         if (host_credit_o)
            host_seen++;
         if (core_io_credit_o)
            io_seen++;
         if (core_dram_credit_o)
            dram_seen++;
      end
   end

   // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_r[0]};
         lfsr_r = lfsr_next(lfsr_r);
      end
      return v;
   endfunction

   // the mailbox and the peripheral port share the core I/O credits
   function automatic int credits_left(input logic [2:0] ch);
      case (ch)
         ch_host: return depth_lp + host_seen - host_sent;
         ch_dram: return depth_lp + dram_seen - dram_sent;
         default: return depth_lp + io_seen - io_sent;
      endcase
   endfunction

   function automatic int out_count(input logic [2:0] ch);
      case (ch)
         ch_host: return host_out_q.size();
         ch_dram: return dram_out_q.size();
         default: return periph_out_q.size();
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("CHECK FAILED: %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("ERROR: %s at %0t", msg, $time);
   endtask

   task automatic wait_credits(input logic [2:0] ch, input int want);
      int n;
      n = 0;
      while (credits_left(ch) < want && n < wait_limit_lp) begin
         @(negedge clk_i);
         n++;
      end
      assert (n < wait_limit_lp) else report_problem("sender credits did not come back in time");
   endtask

   task automatic wait_for_beats(input logic [2:0] ch, input int want);
      int n;
      n = 0;
      while (out_count(ch) < want && n < wait_limit_lp) begin
         @(negedge clk_i);
         n++;
      end
      assert (n < wait_limit_lp) else report_problem("an expected output beat never appeared");
   endtask

   task automatic drive_beat(input logic [2:0] ch, input logic we, input logic [31:0] addr,
                             input logic [31:0] data);
      wait_credits(ch, 1);
      case (ch)
         ch_host: begin
            host_req_v_i = 1'b1;
            host_req_i   = {we, addr[29:0], data};
            host_sent++;
         end
         ch_dram: begin
            core_dram_req_v_i = 1'b1;
            core_dram_req_i   = {we, addr, data};
            dram_sent++;
         end
         default: begin
            core_io_req_v_i = 1'b1;
            core_io_req_i   = {addr, data};
            io_sent++;
         end
      endcase
      @(negedge clk_i);
      host_req_v_i      = 1'b0;
      core_dram_req_v_i = 1'b0;
      core_io_req_v_i   = 1'b0;
   endtask

   task automatic return_credit(input logic [2:0] ch);
      case (ch)
         ch_host: core_host_credit_i = 1'b1;
         ch_dram: dram_credit_i      = 1'b1;
         default: periph_credit_i    = 1'b1;
      endcase
      @(negedge clk_i);
      core_host_credit_i = 1'b0;
      dram_credit_i      = 1'b0;
      periph_credit_i    = 1'b0;
   endtask

   // pops the oldest beat of a channel, compares it and hands the credit back
   task automatic take_beat(input logic [2:0] ch, input logic we, input logic [31:0] addr,
                            input logic [31:0] data);
      bridge_pkg::core_req_t req;
      bridge_pkg::io_wr_t    wr;
      string                 name;
      wait_for_beats(ch, 1);
      if (out_count(ch) == 0)
         return;
      if (ch == ch_periph) begin
         wr = periph_out_q.pop_front();
         check_value("periph_wr_o.addr", wr.addr, addr);
         check_value("periph_wr_o.data", wr.data, data);
      end else begin
         if (ch == ch_host) begin
            req  = host_out_q.pop_front();
            name = "core_host_req_o";
         end else begin
            req  = dram_out_q.pop_front();
            name = "dram_req_o";
         end
         check_value({name, ".addr"}, req.addr, addr);
         check_value({name, ".data"}, req.data, data);
         check_value({name, ".we"}, 32'(req.we), 32'(we));
      end
      return_credit(ch);
   endtask

   task automatic csr_write(input logic [3:0] idx, input logic [31:0] data);
      csr_req_v_i = 1'b1;
      csr_req_i   = {1'b1, idx, data};
      @(negedge clk_i);
      csr_req_v_i = 1'b0;
   endtask

   // read data is valid for exactly the cycle after the request
   task automatic csr_read(input logic [3:0] idx, input logic [31:0] exp);
      csr_req_v_i = 1'b1;
      csr_req_i   = {1'b0, idx, 32'h0};
      @(negedge clk_i);
      csr_req_v_i = 1'b0;
      check_value("csr_rdata_v_o", 32'(csr_rdata_v_o), 32'h1);
      check_value("csr_rdata_o", csr_rdata_o, exp);
      @(negedge clk_i);
      check_value("csr_rdata_v_o", 32'(csr_rdata_v_o), 32'h0);
   endtask

   task automatic check_idle(input logic [31:0] exp_reset);
      check_value("core_reset_o", 32'(core_reset_o), exp_reset);
      check_value("csr_rdata_v_o", 32'(csr_rdata_v_o), 32'h0);
      check_value("core_host_req_v_o", 32'(core_host_req_v_o), 32'h0);
      check_value("periph_wr_v_o", 32'(periph_wr_v_o), 32'h0);
      check_value("dram_req_v_o", 32'(dram_req_v_o), 32'h0);
      check_value("host_credit_o", 32'(host_credit_o), 32'h0);
      check_value("core_io_credit_o", 32'(core_io_credit_o), 32'h0);
      check_value("core_dram_credit_o", 32'(core_dram_credit_o), 32'h0);
   endtask

   // the first depth_lp beats use up the core credits, the next depth_lp fill the FIFO
   task automatic host_burst(input logic [31:0] addr, input logic [31:0] exp_addr);
      logic [31:0] data_q [$];
      logic        we_q [$];
      int          seen;
      for (int i = 0; i < 2 * depth_lp; i++) begin
         data_q.push_back(random_bits(32));
         we_q.push_back(random_bits(1) != 0);
         drive_beat(ch_host, we_q[i], addr + 4 * i, data_q[i]);
      end
      wait_for_beats(ch_host, depth_lp);
      seen = host_seen;
      repeat (3 * depth_lp) @(negedge clk_i);
      assert (host_seen == seen)
      else report_problem("host credit came back while the core held all its credits");
      assert (host_out_q.size() == depth_lp)
      else report_problem("a host request reached the core without a credit");
      for (int i = 0; i < 2 * depth_lp; i++)
         take_beat(ch_host, we_q[i], exp_addr + 4 * i, data_q[i]);
      wait_credits(ch_host, depth_lp);
   endtask

   task automatic run_row(input row_t r);
      logic [31:0] data;
      logic        we;
      case (r.op)
         op_level: begin
            check_idle(r.exp);
            // the profiler clears on the edge after core reset rises
            @(negedge clk_i);
         end
         op_write: csr_write(r.addr[3:0], r.data);
         op_read:  csr_read(r.addr[3:0], r.exp);
         op_burst: host_burst(r.addr, r.exp);
         default: begin
            // mailbox bytes come from the table, the other beats carry filler data
            data = (r.ch == ch_mbox) ? r.data : random_bits(32);
            we   = (random_bits(1) != 0);
            drive_beat(r.ch, we, r.addr, data);
            if (r.ch != ch_mbox)
               take_beat(r.ch, we, r.exp, data);
            wait_credits(r.ch, depth_lp);
         end
      endcase
   endtask

   task automatic add_row(input logic [2:0] op, input logic [2:0] ch, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
      rows.push_back({op, ch, addr, data, exp});
   endtask

   task automatic load_table();
      // reset state, then start the core with a DRAM base
      add_row(op_level, ch_top, 0, 0, 1);
      add_row(op_read, ch_csr, `BRIDGE_CSR_CTRL, 0, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_DRAM_OK, 0, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_DRAM_BASE, 0, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_MBOX_COUNT, 0, 0);
      for (int w = 0; w < 4; w++)
         add_row(op_read, ch_csr, `BRIDGE_CSR_PROF0 + w, 0, 0);
      add_row(op_write, ch_csr, `BRIDGE_CSR_CTRL, 1, 0);
      add_row(op_write, ch_csr, `BRIDGE_CSR_DRAM_OK, 1, 0);
      add_row(op_write, ch_csr, `BRIDGE_CSR_DRAM_BASE, 32'h1000_0000, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_CTRL, 0, 1);
      add_row(op_read, ch_csr, `BRIDGE_CSR_DRAM_OK, 0, 1);
      add_row(op_read, ch_csr, `BRIDGE_CSR_DRAM_BASE, 0, 32'h1000_0000);
      add_row(op_level, ch_top, 0, 0, 0);
      // host bit 29 flips into core bit 31
      add_row(op_send, ch_host, 32'h0000_1234, 0, 32'h8000_1234);
      add_row(op_send, ch_host, 32'h2000_0010, 0, 32'h0000_0010);
      add_row(op_burst, ch_host, 32'h0000_0100, 0, 32'h8000_0100);
      // bits 29 to 23 of 0x8080_0040 select profiler bit 1
      add_row(op_send, ch_dram, 32'h8080_0040, 0, 32'h1080_0040);
      add_row(op_read, ch_csr, `BRIDGE_CSR_PROF0, 0, 32'h0000_0002);
      add_row(op_send, ch_mbox, 32'h0010_0000, 32'h41, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_MBOX_COUNT, 0, 1);
      add_row(op_read, ch_csr, `BRIDGE_CSR_MBOX_DATA, 0, 32'h41);
      add_row(op_read, ch_csr, `BRIDGE_CSR_MBOX_COUNT, 0, 0);
      add_row(op_read, ch_csr, `BRIDGE_CSR_MBOX_DATA, 0, 0);
      add_row(op_send, ch_periph, 32'h1000_0000, 0, 32'h1000_0000);
      // stopping the core wipes the profiler
      add_row(op_write, ch_csr, `BRIDGE_CSR_CTRL, 0, 0);
      add_row(op_level, ch_top, 0, 0, 1);
      for (int w = 0; w < 4; w++)
         add_row(op_read, ch_csr, `BRIDGE_CSR_PROF0 + w, 0, 0);
   endtask

   initial begin
      clk_i              = 1'b0;
      reset_i            = 1'b1;
      csr_req_v_i        = 1'b0;
      csr_req_i          = '0;
      host_req_v_i       = 1'b0;
      host_req_i         = '0;
      core_host_credit_i = 1'b0;
      core_io_req_v_i    = 1'b0;
      core_io_req_i      = '0;
      periph_credit_i    = 1'b0;
      core_dram_req_v_i  = 1'b0;
      core_dram_req_i    = '0;
      dram_credit_i      = 1'b0;
      lfsr_r             = 32'he537;
      host_seen          = 0;
      io_seen            = 0;
      dram_seen          = 0;
      host_sent          = 0;
      io_sent            = 0;
      dram_sent          = 0;
      errors             = 0;
      checks             = 0;
      load_table();
      repeat (10) @(negedge clk_i);
      reset_i = 1'b0;
      @(negedge clk_i);
      foreach (rows[k])
         run_row(rows[k]);
      repeat (2) @(negedge clk_i);
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : watchdog
      int limit;
      repeat (10) @(posedge clk_i);
      limit = rows.size() * 60 + 100;
      repeat (limit) @(posedge clk_i);
      $display("watchdog expired after %0d cycles, %0d errors in %0d checks",
               limit, errors, checks);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
bridge_pkg.sv
credit_fifo.sv
csr_regfile.sv
host_window.sv
io_router.sv
dram_window.sv
zynq_bridge_top.sv
tb_zynq_bridge.sv
